//--- design/commit_if.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

interface commit_if;

    logic               reg_we;
    logic [`REG_AW-1:0] reg_addr;
    logic [`DATA_W-1:0] reg_data;
    logic               hi_we;   // hi, lo and cop0 come from the memory stage
    logic [`DATA_W-1:0] hi_data;
    logic               lo_we;
    logic [`DATA_W-1:0] lo_data;
    logic               cop0_we;
    logic [`DATA_W-1:0] cop0_data;

    modport retire (
        output reg_we, reg_addr, reg_data, hi_we, hi_data,
               lo_we, lo_data, cop0_we, cop0_data
    );

    modport regs (
        input reg_we, reg_addr, reg_data, hi_we, hi_data,
              lo_we, lo_data, cop0_we, cop0_data
    );

endinterface

//--- design/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and instruction word width
`define DATA_W 32

// general register index width
`define REG_AW 5

// number of general registers incl. register zero
`define REG_COUNT 32

`endif

//--- design/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  logic [`DATA_W-1:0] instr,
    output logic [`REG_AW-1:0] rs_addr,
    output logic [`REG_AW-1:0] rt_addr,
    input  logic [`DATA_W-1:0] rs_data,
    input  logic [`DATA_W-1:0] rt_data,
    input  logic [`DATA_W-1:0] hi,
    input  logic [`DATA_W-1:0] lo,
    input  logic [`DATA_W-1:0] cop0,
    input  forward_info_t      decode_forward_info,
    output pipeline_signal_t   ps_decode,
    output pipeline_signal_t   ps_execute_in
);

    logic               valid_q;
    logic [`DATA_W-1:0] instr_q;
    unpack_t            ei;
    pipeline_signal_t   ps_raw;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            instr_q <= '0;
        end else begin
            valid_q <= instr_valid;
            instr_q <= instr;
        end
    end

    extract_instruction decode_ei_i (
        .instruction (instr_q),
        .ei          (ei)
    );

    assign rs_addr = ei.rs;
    assign rt_addr = ei.rt;

    always_comb begin
        ps_raw                    = '0;
        ps_raw.valid              = valid_q;
        ps_raw.instruction        = instr_q;
        ps_raw.control.alu_op     = ei.alu_op;
        ps_raw.control.use_imm    = ei.use_imm;
        ps_raw.control.write_hi   = ei.alu_op inside {ALU_MULTU, ALU_MTHI};
        ps_raw.control.write_lo   = ei.alu_op inside {ALU_MULTU, ALU_MTLO};
        ps_raw.control.write_cop0 = (ei.alu_op == ALU_MTC0);
        ps_raw.control.write_reg  = !(ei.alu_op inside {ALU_NONE, ALU_MULTU, ALU_MTHI,
                                                        ALU_MTLO, ALU_MTC0});
        if (ps_raw.control.write_reg)
            ps_raw.dest_reg = (ei.use_imm || ei.alu_op == ALU_MFC0) ? ei.rt : ei.rd;
        ps_raw.rs   = rs_data;
        ps_raw.rt   = rt_data;
        ps_raw.hi   = hi;
        ps_raw.lo   = lo;
        ps_raw.cop0 = cop0;
    end

    assign ps_decode = process_forward_data(ps_raw, decode_forward_info);

    always_comb begin
        ps_execute_in = ps_decode;
        if (!ps_decode.valid) begin // bubble carries no writes
            ps_execute_in.control  = '0;
            ps_execute_in.dest_reg = '0;
        end
    end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  pipeline_signal_t ps_execute_in,
    input  forward_info_t    execute_forward_info,
    output pipeline_signal_t ps_execute,
    output pipeline_signal_t ps_memory_in
);

    unpack_t              ei;
    pipeline_signal_t     ps_fwd;
    logic [`DATA_W-1:0]   imm_sext;
    logic [`DATA_W-1:0]   imm_zext;
    logic [`DATA_W-1:0]   op_b;
    logic [`DATA_W-1:0]   result;
    logic [2*`DATA_W-1:0] product;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ps_execute.valid       <= 1'b0;
            ps_execute.instruction <= '0;
            ps_execute.control     <= '0;
            ps_execute.dest_reg    <= '0;
        end else begin
            ps_execute <= ps_execute_in;
        end
    end

    extract_instruction execute_ei_i (
        .instruction (ps_execute.instruction),
        .ei          (ei)
    );

    assign ps_fwd = process_forward_data(ps_execute, execute_forward_info);

    assign imm_sext = {{(`DATA_W-16){ei.imm[15]}}, ei.imm};
    assign imm_zext = {{(`DATA_W-16){1'b0}}, ei.imm};
    assign product  = {{`DATA_W{1'b0}}, ps_fwd.rs} * {{`DATA_W{1'b0}}, ps_fwd.rt};

    always_comb begin
        op_b = ps_fwd.rt;
        if (ps_fwd.control.use_imm)
            op_b = (ps_fwd.control.alu_op == ALU_ORI) ? imm_zext : imm_sext;
    end

    always_comb begin
        case (ps_fwd.control.alu_op)
            ALU_ADDU, ALU_ADDIU: result = ps_fwd.rs + op_b;
            ALU_SUBU:            result = ps_fwd.rs - op_b;
            ALU_AND:             result = ps_fwd.rs & op_b;
            ALU_OR, ALU_ORI:     result = ps_fwd.rs | op_b;
            ALU_XOR:             result = ps_fwd.rs ^ op_b;
            ALU_SLTU:            result = {{(`DATA_W-1){1'b0}}, ps_fwd.rs < op_b};
            ALU_LUI:             result = {ei.imm, 16'b0};
            ALU_MFHI:            result = ps_fwd.hi;
            ALU_MFLO:            result = ps_fwd.lo;
            ALU_MFC0:            result = ps_fwd.cop0;
            default:             result = '0;
        endcase
    end

    always_comb begin
        ps_memory_in                = ps_fwd;
        ps_memory_in.dest_reg_data  = result;
        ps_memory_in.dest_hi_data   = product[2*`DATA_W-1:`DATA_W];
        ps_memory_in.dest_lo_data   = product[`DATA_W-1:0];
        ps_memory_in.dest_cop0_data = ps_fwd.rt; // mtc0 moves rt
        if (ps_fwd.control.alu_op == ALU_MTHI)
            ps_memory_in.dest_hi_data = ps_fwd.rs;
        if (ps_fwd.control.alu_op == ALU_MTLO)
            ps_memory_in.dest_lo_data = ps_fwd.rs;
    end

endmodule

//--- design/extract_instruction.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module extract_instruction
    import isa_pkg::*;
(
    input  logic [`DATA_W-1:0] instruction,
    output unpack_t            ei
);

    always_comb begin
        ei         = '0;
        ei.rs      = instruction[25:21];
        ei.rt      = instruction[20:16];
        ei.rd      = instruction[15:11];
        ei.imm     = instruction[15:0];
        ei.alu_op  = ALU_NONE;
        ei.use_imm = 1'b0;
        case (instruction[31:26])
            OP_SPECIAL: begin
                case (instruction[5:0])
                    FN_ADDU:  ei.alu_op = ALU_ADDU;
                    FN_SUBU:  ei.alu_op = ALU_SUBU;
                    FN_AND:   ei.alu_op = ALU_AND;
                    FN_OR:    ei.alu_op = ALU_OR;
                    FN_XOR:   ei.alu_op = ALU_XOR;
                    FN_SLTU:  ei.alu_op = ALU_SLTU;
                    FN_MULTU: ei.alu_op = ALU_MULTU;
                    FN_MTHI:  ei.alu_op = ALU_MTHI;
                    FN_MTLO:  ei.alu_op = ALU_MTLO;
                    FN_MFHI:  ei.alu_op = ALU_MFHI;
                    FN_MFLO:  ei.alu_op = ALU_MFLO;
                    default:  ei.alu_op = ALU_NONE; // nop lands here
                endcase
            end
            OP_ADDIU: begin
                ei.alu_op  = ALU_ADDIU;
                ei.use_imm = 1'b1;
            end
            OP_ORI: begin
                ei.alu_op  = ALU_ORI;
                ei.use_imm = 1'b1;
            end
            OP_LUI: begin
                ei.alu_op  = ALU_LUI;
                ei.use_imm = 1'b1;
            end
            OP_COP0: begin
                if (instruction[25:21] == COP0_MT)
                    ei.alu_op = ALU_MTC0;
                else if (instruction[25:21] == COP0_MF)
                    ei.alu_op = ALU_MFC0;
            end
            default: ei.alu_op = ALU_NONE;
        endcase
    end

endmodule

//--- design/isa_pkg.sv
`include "cpu_settings.svh"

package isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_COP0    = 6'h10
    } opcode_e;

    typedef enum logic [5:0] {
        FN_MFHI  = 6'h10,
        FN_MTHI  = 6'h11,
        FN_MFLO  = 6'h12,
        FN_MTLO  = 6'h13,
        FN_MULTU = 6'h19,
        FN_ADDU  = 6'h21,
        FN_SUBU  = 6'h23,
        FN_AND   = 6'h24,
        FN_OR    = 6'h25,
        FN_XOR   = 6'h26,
        FN_SLTU  = 6'h2b
    } funct_e;

    localparam logic [4:0] COP0_MF = 5'h00; // rs field of mfc0
    localparam logic [4:0] COP0_MT = 5'h04; // rs field of mtc0

    typedef enum logic [4:0] {
        ALU_NONE, ALU_ADDU, ALU_SUBU, ALU_AND, ALU_OR, ALU_XOR, ALU_SLTU,
        ALU_MULTU, ALU_MTHI, ALU_MTLO, ALU_MFHI, ALU_MFLO,
        ALU_ADDIU, ALU_ORI, ALU_LUI, ALU_MTC0, ALU_MFC0
    } alu_op_e;

    typedef struct packed {
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] rd;
        logic [15:0]        imm;
        alu_op_e            alu_op;
        logic               use_imm;
    } unpack_t;

endpackage

//--- design/main_forwarder.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module main_forwarder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  pipeline_signal_t ps_decode,
    input  pipeline_signal_t ps_execute,
    input  pipeline_signal_t ps_memory,
    input  pipeline_signal_t ps_write_back,
    output forward_info_t    decode_forward_info,
    output forward_info_t    execute_forward_info
);

    unpack_t decode_unpack;
    unpack_t execute_unpack;

    extract_instruction decode_ei_i (
        .instruction (ps_decode.instruction),
        .ei          (decode_unpack)
    );

    extract_instruction execute_ei_i (
        .instruction (ps_execute.instruction),
        .ei          (execute_unpack)
    );

    // a stage hits when it writes a nonzero register equal to target
    function automatic forward_element_t test_one(
        input pipeline_signal_t   ps,
        input logic [`REG_AW-1:0] target
    );
        forward_element_t fe;
        fe = '0;
        if (ps.control.write_reg && ps.dest_reg != '0 && ps.dest_reg == target) begin
            fe.take = 1'b1;
            fe.data = ps.dest_reg_data;
        end
        return fe;
    endfunction

    function automatic forward_element_t from_memory(
        input logic               we,
        input logic [`DATA_W-1:0] data
    );
        forward_element_t fe;
        fe.take = we;
        fe.data = we ? data : '0;
        return fe;
    endfunction

    always_comb begin
        decode_forward_info  = '0;
        execute_forward_info = '0;

        execute_forward_info.rs = test_one(ps_memory, execute_unpack.rs);
        execute_forward_info.rt = test_one(ps_memory, execute_unpack.rt);
        if (!execute_forward_info.rs.take)
            execute_forward_info.rs = test_one(ps_write_back, execute_unpack.rs);
        if (!execute_forward_info.rt.take)
            execute_forward_info.rt = test_one(ps_write_back, execute_unpack.rt);

        // memory stage commits next edge so decode only needs write-back
        decode_forward_info.rs = test_one(ps_write_back, decode_unpack.rs);
        decode_forward_info.rt = test_one(ps_write_back, decode_unpack.rt);

        execute_forward_info.hi = from_memory(ps_memory.control.write_hi,
                                              ps_memory.dest_hi_data);
        execute_forward_info.lo = from_memory(ps_memory.control.write_lo,
                                              ps_memory.dest_lo_data);
        execute_forward_info.cop0 = from_memory(ps_memory.control.write_cop0,
                                                ps_memory.dest_cop0_data);
        decode_forward_info.hi   = execute_forward_info.hi;
        decode_forward_info.lo   = execute_forward_info.lo;
        decode_forward_info.cop0 = execute_forward_info.cop0;
    end

endmodule

//--- design/pipe_core_top.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module pipe_core_top
    import pipe_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  logic [`DATA_W-1:0] instr,
    output logic               wb_valid,
    output logic               wb_we,
    output logic [`REG_AW-1:0] wb_reg,
    output logic [`DATA_W-1:0] wb_data
);

    logic [`REG_AW-1:0] rs_addr, rt_addr;
    logic [`DATA_W-1:0] rs_data, rt_data, hi, lo, cop0;
    pipeline_signal_t   ps_decode, ps_execute_in, ps_execute;
    pipeline_signal_t   ps_memory_in, ps_memory, ps_write_back;
    forward_info_t      decode_forward_info, execute_forward_info;

    commit_if commit_bus ();

    reg_file reg_file_i (
        .clk, .rst_n, .rs_addr, .rt_addr, .rs_data, .rt_data,
        .hi, .lo, .cop0, .commit (commit_bus.regs)
    );

    decode_stage decode_stage_i (
        .clk, .rst_n, .instr_valid, .instr, .rs_addr, .rt_addr,
        .rs_data, .rt_data, .hi, .lo, .cop0,
        .decode_forward_info, .ps_decode, .ps_execute_in
    );

    execute_stage execute_stage_i (
        .clk, .rst_n, .ps_execute_in, .execute_forward_info,
        .ps_execute, .ps_memory_in
    );

    retire_stage retire_stage_i (
        .clk, .rst_n, .ps_memory_in, .ps_memory, .ps_write_back,
        .commit (commit_bus.retire),
        .wb_valid, .wb_we, .wb_reg, .wb_data
    );

    main_forwarder main_forwarder_i (
        .ps_decode, .ps_execute, .ps_memory, .ps_write_back,
        .decode_forward_info, .execute_forward_info
    );

endmodule

//--- design/pipe_pkg.sv
`include "cpu_settings.svh"

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        logic    write_reg;
        logic    write_hi;
        logic    write_lo;
        logic    write_cop0;
        alu_op_e alu_op;
        logic    use_imm;
    } control_t;

    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] instruction;
        control_t           control;
        logic [`REG_AW-1:0] dest_reg;
        logic [`DATA_W-1:0] rs, rt, hi, lo, cop0;        // operand values
        logic [`DATA_W-1:0] dest_reg_data, dest_hi_data;
        logic [`DATA_W-1:0] dest_lo_data, dest_cop0_data;
    } pipeline_signal_t;

    typedef struct packed {
        logic               take;
        logic [`DATA_W-1:0] data;
    } forward_element_t;

    typedef struct packed {
        forward_element_t rs, rt, lo, hi, cop0;
    } forward_info_t;

    // bypassed values replace what the register file gave
    function automatic pipeline_signal_t process_forward_data(
        input pipeline_signal_t ps,
        input forward_info_t    fi
    );
        pipeline_signal_t res;
        res = ps;
        if (fi.rs.take) res.rs = fi.rs.data;
        if (fi.rt.take) res.rt = fi.rt.data;
        if (fi.hi.take) res.hi = fi.hi.data;
        if (fi.lo.take) res.lo = fi.lo.data;
        if (fi.cop0.take) res.cop0 = fi.cop0.data;
        return res;
    endfunction

endpackage

//--- design/reg_file.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`REG_AW-1:0] rs_addr,
    input  logic [`REG_AW-1:0] rt_addr,
    output logic [`DATA_W-1:0] rs_data,
    output logic [`DATA_W-1:0] rt_data,
    output logic [`DATA_W-1:0] hi,
    output logic [`DATA_W-1:0] lo,
    output logic [`DATA_W-1:0] cop0,
    commit_if.regs             commit
);

    logic [`DATA_W-1:0] gpr [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++)
                gpr[i] <= '0;
            hi   <= '0;
            lo   <= '0;
            cop0 <= '0;
        end else begin
            if (commit.reg_we && commit.reg_addr != '0)
                gpr[commit.reg_addr] <= commit.reg_data;
            if (commit.hi_we)
                hi <= commit.hi_data;
            if (commit.lo_we)
                lo <= commit.lo_data;
            if (commit.cop0_we)
                cop0 <= commit.cop0_data;
        end
    end

    // old value on a same-cycle write
    assign rs_data = (rs_addr == '0) ? '0 : gpr[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : gpr[rt_addr];

endmodule

//--- design/retire_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module retire_stage
    import pipe_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  pipeline_signal_t   ps_memory_in,
    output pipeline_signal_t   ps_memory,
    output pipeline_signal_t   ps_write_back,
    commit_if.retire           commit,
    output logic               wb_valid,
    output logic               wb_we,
    output logic [`REG_AW-1:0] wb_reg,
    output logic [`DATA_W-1:0] wb_data
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ps_memory.valid        <= 1'b0;
            ps_memory.control      <= '0;
            ps_memory.dest_reg     <= '0;
            ps_write_back.valid    <= 1'b0;
            ps_write_back.control  <= '0;
            ps_write_back.dest_reg <= '0;
        end else begin
            ps_memory     <= ps_memory_in;
            ps_write_back <= ps_memory;
        end
    end

    assign wb_valid = ps_write_back.valid;
    assign wb_we    = ps_write_back.control.write_reg && ps_write_back.dest_reg != '0;
    assign wb_reg   = ps_write_back.dest_reg;
    assign wb_data  = ps_write_back.control.write_reg ? ps_write_back.dest_reg_data : '0;

    assign commit.reg_we    = wb_we;
    assign commit.reg_addr  = ps_write_back.dest_reg;
    assign commit.reg_data  = ps_write_back.dest_reg_data;
    assign commit.hi_we     = ps_memory.control.write_hi; // special regs leave from memory
    assign commit.hi_data   = ps_memory.dest_hi_data;
    assign commit.lo_we     = ps_memory.control.write_lo;
    assign commit.lo_data   = ps_memory.dest_lo_data;
    assign commit.cop0_we   = ps_memory.control.write_cop0;
    assign commit.cop0_data = ps_memory.dest_cop0_data;

endmodule

//--- files.f
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/commit_if.sv
design/extract_instruction.sv
design/main_forwarder.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/retire_stage.sv
design/pipe_core_top.sv
sim/pipe_core_asserts.sv
sim/pipe_core_tb.sv

//--- sim/pipe_core_asserts.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module pipe_core_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               instr_valid,
    input logic               wb_valid,
    input logic               wb_we,
    input logic [`REG_AW-1:0] wb_reg
);

    int violations = 0; // read by the testbench at the end

    quiet_in_reset_a: assert property (@(posedge clk) !rst_n |=> !wb_valid && !wb_we)
        else begin
            violations++;
            $error("write-back active while in reset");
        end

    quiet_after_release_a: assert property (@(posedge clk) $rose(rst_n) |=> !wb_valid && !wb_we)
        else begin
            violations++;
            $error("write-back active in the cycle after reset release");
        end

    // four register stages between instr_valid and wb_valid
    wb_latency_a: assert property (@(posedge clk)
        rst_n && $past(rst_n, 4) |-> wb_valid == $past(instr_valid, 4))
        else begin
            violations++;
            $error("wb_valid does not follow instr_valid by four cycles");
        end

    // a bubble must not leave a register write behind
    wb_we_legal_a: assert property (@(posedge clk) wb_we |-> wb_valid && wb_reg != '0)
        else begin
            violations++;
            $error("wb_we reported for register zero or outside a valid report");
        end

endmodule

bind pipe_core_top pipe_core_asserts pipe_core_asserts_i (
    .clk, .rst_n, .instr_valid, .wb_valid, .wb_we, .wb_reg
);

//--- sim/pipe_core_tb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module pipe_core_tb;

    typedef enum int {
        I_ADDU, I_SUBU, I_AND, I_OR, I_XOR, I_SLTU, I_ADDIU, I_ORI, I_LUI,
        I_MULTU, I_MTHI, I_MTLO, I_MFHI, I_MFLO, I_MTC0, I_MFC0, I_NOP
    } op_t;

    logic                      clk;
    logic                      rst_n;
    logic                      instr_valid;
    logic [`DATA_W-1:0]        instr;
    logic                      wb_valid;
    logic                      wb_we;
    logic [`REG_AW-1:0]        wb_reg;
    logic [`DATA_W-1:0]        wb_data;
    logic [31:0]               lfsr = 32'ha445;
    logic [`DATA_W-1:0]        model_gpr [`REG_COUNT];
    logic [`DATA_W-1:0]        model_hi;
    logic [`DATA_W-1:0]        model_lo;
    logic [`DATA_W-1:0]        model_cop0;
    logic [`REG_AW+`DATA_W:0]  expected [$]; // {we, reg, data} in issue order
    op_t                       pool [$];
    int                        errors = 0;
    int                        checks = 0;
    int                        tests = 0;
    int                        failed_tests = 0;
    int                        issued;
    int                        err_mark;

    pipe_core_top pipe_core_top_i (
        .clk, .rst_n, .instr_valid, .instr, .wb_valid, .wb_we, .wb_reg, .wb_data
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [2:0] v;
        v = 3'(rand_bits(3));
        return 5'((v > 3'd4) ? v - 3'd4 : v); // pool of 0 to 4
    endfunction

    function automatic int error_total();
        return errors + pipe_core_top_i.pipe_core_asserts_i.violations;
    endfunction

    function automatic logic [31:0] encode(input op_t op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [15:0] imm);
        logic [31:0] word;
        case (op)
            I_ADDU:  word = {6'h00, rs, rt, rd, 5'd0, 6'h21};
            I_SUBU:  word = {6'h00, rs, rt, rd, 5'd0, 6'h23};
            I_AND:   word = {6'h00, rs, rt, rd, 5'd0, 6'h24};
            I_OR:    word = {6'h00, rs, rt, rd, 5'd0, 6'h25};
            I_XOR:   word = {6'h00, rs, rt, rd, 5'd0, 6'h26};
            I_SLTU:  word = {6'h00, rs, rt, rd, 5'd0, 6'h2b};
            I_MULTU: word = {6'h00, rs, rt, rd, 5'd0, 6'h19};
            I_MTHI:  word = {6'h00, rs, rt, rd, 5'd0, 6'h11};
            I_MTLO:  word = {6'h00, rs, rt, rd, 5'd0, 6'h13};
            I_MFHI:  word = {6'h00, rs, rt, rd, 5'd0, 6'h10};
            I_MFLO:  word = {6'h00, rs, rt, rd, 5'd0, 6'h12};
            I_ADDIU: word = {6'h09, rs, rt, imm};
            I_ORI:   word = {6'h0d, rs, rt, imm};
            I_LUI:   word = {6'h0f, 5'd0, rt, imm};
            I_MTC0:  word = {6'h10, 5'h04, rt, rd, 11'd0};
            I_MFC0:  word = {6'h10, 5'h00, rt, rd, 11'd0};
            default: word = '0; // sll r0 acts as nop
        endcase
        return word;
    endfunction

    // architectural effect in program order and the expected report
    function automatic void run_model(input op_t op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd,
                                      input logic [15:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0]  dest;
        logic        writes;
        logic        we;
        a      = model_gpr[rs];
        b      = model_gpr[rt];
        res    = '0;
        dest   = (op inside {I_ADDIU, I_ORI, I_LUI, I_MFC0}) ? rt : rd;
        writes = !(op inside {I_MULTU, I_MTHI, I_MTLO, I_MTC0, I_NOP});
        case (op)
            I_ADDU:  res = a + b;
            I_SUBU:  res = a - b;
            I_AND:   res = a & b;
            I_OR:    res = a | b;
            I_XOR:   res = a ^ b;
            I_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
            I_ADDIU: res = a + {{16{imm[15]}}, imm};
            I_ORI:   res = a | {16'd0, imm};
            I_LUI:   res = {imm, 16'd0};
            I_MULTU: {model_hi, model_lo} = {32'd0, a} * {32'd0, b};
            I_MTHI:  model_hi = a;
            I_MTLO:  model_lo = a;
            I_MTC0:  model_cop0 = b;
            I_MFHI:  res = model_hi;
            I_MFLO:  res = model_lo;
            I_MFC0:  res = model_cop0;
            default: res = '0;
        endcase
        we = writes && dest != 5'd0;
        expected.push_back({we, writes ? dest : 5'd0, writes ? res : 32'd0});
        if (we)
            model_gpr[dest] = res;
    endfunction

    task automatic issue(input op_t op, input logic [4:0] rs, input logic [4:0] rt,
                         input logic [4:0] rd, input logic [15:0] imm);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = encode(op, rs, rt, rd, imm);
        run_model(op, rs, rt, rd, imm);
        issued++;
    endtask

    task automatic bubble();
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = rand_bits(32); // garbage must not write
    endtask

    task automatic run_random(input int count, input bit with_bubbles);
        op_t op;
        for (int n = 0; n < count; n++) begin
            if (with_bubbles && rand_bits(2) == 0)
                bubble();
            op = pool[rand_bits(5) % pool.size()];
            issue(op, pick_reg(), pick_reg(), pick_reg(), 16'(rand_bits(16)));
        end
    endtask

    task automatic start_test();
        issued   = 0;
        err_mark = error_total();
    endtask

    task automatic drain_and_report(input string name);
        int waited;
        bubble();
        waited = 0;
        while (expected.size() != 0 && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (expected.size() != 0) begin
            $display("test %s: %0d write-back reports never arrived", name, expected.size());
            errors++;
            expected.delete();
        end
        tests++;
        if (error_total() != err_mark)
            failed_tests++;
        $display("test %-12s %4d instructions, %0d errors", name, issued, error_total() - err_mark);
    endtask

    always @(negedge clk) begin
        logic [`REG_AW+`DATA_W:0] head;
        if (rst_n === 1'b1 && wb_valid === 1'b1) begin
            checks++;
            if (expected.size() == 0) begin
                errors++;
                $display("write-back report at %0t ns with no instruction outstanding", $time);
            end else begin
                head = expected.pop_front();
                assert ({wb_we, wb_reg, wb_data} === head) else begin
                    errors++;
                    $display("** Error at %0t ns: got we=%0b reg=%0d data=%h, expected %0b %0d %h",
                             $time, wb_we, wb_reg, wb_data,
                             head[`REG_AW+`DATA_W], head[`REG_AW+`DATA_W-1:`DATA_W],
                             head[`DATA_W-1:0]);
                end
            end
        end
    end

    initial begin
        for (int c = 0; c < 5000; c++)
            @(posedge clk);
        $display("run did not complete within 5000 cycles");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < `REG_COUNT; i++)
            model_gpr[i] = '0;
        model_hi   = '0;
        model_lo   = '0;
        model_cop0 = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test();
        repeat (8) bubble();
        drain_and_report("reset_idle");

        start_test();
        pool = '{I_ADDU, I_SUBU, I_AND, I_OR, I_XOR, I_SLTU, I_ADDIU, I_ORI, I_LUI};
        run_random(60, 1'b0);
        drain_and_report("alu_chain");

        start_test();
        for (int n = 0; n < 4; n++) begin // two writers in flight so memory must win
            issue(I_ADDIU, 5'd0, 5'(n + 1), 5'd0, 16'(rand_bits(16)));
            issue(I_ORI, 5'd0, 5'(n + 1), 5'd0, 16'(rand_bits(16)));
            issue(I_ADDU, 5'(n + 1), 5'(n + 1), 5'((n + 1) % 4 + 1), 16'd0);
            issue(I_SUBU, 5'(n + 1), 5'((n + 1) % 4 + 1), 5'(n + 1), 16'd0);
        end
        drain_and_report("mem_over_wb");

        start_test();
        pool = '{I_MULTU, I_MTHI, I_MTLO, I_MFHI, I_MFLO, I_ADDIU, I_LUI, I_ORI, I_ADDU};
        run_random(60, 1'b0);
        drain_and_report("hi_lo");

        start_test();
        pool = '{I_MTC0, I_MFC0, I_MFC0, I_ADDIU, I_LUI, I_ORI};
        run_random(40, 1'b0);
        drain_and_report("cop0");

        start_test();
        for (int n = 0; n < 4; n++) begin
            issue(I_ADDIU, 5'(n + 1), 5'd0, 5'd0, 16'(rand_bits(16)));
            issue(I_OR, 5'(n + 1), 5'(n + 1), 5'd0, 16'd0);
            issue(I_ADDU, 5'd0, 5'd0, 5'(n + 1), 16'd0);
            issue(I_XOR, 5'(n + 1), 5'd0, 5'(n + 1), 16'd0);
            issue(I_MFHI, 5'd0, 5'd0, 5'd0, 16'd0);
        end
        drain_and_report("zero_reg");

        start_test();
        pool = '{I_ADDU, I_SUBU, I_XOR, I_SLTU, I_ADDIU, I_ORI, I_LUI, I_MULTU,
                 I_MTHI, I_MTLO, I_MFHI, I_MFLO, I_MTC0, I_MFC0, I_NOP};
        run_random(80, 1'b1);
        drain_and_report("bubbles");

        $display("%0d tests, %0d with errors, %0d reports checked, %0d errors",
                 tests, failed_tests, checks, error_total());
        if (error_total() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
